//--- Makefile
# Verilator simulation of the CSI-2 receiver back end

VERILATOR ?= verilator
TOP       ?= tb_csi_rx
FILELIST  ?= csi_rx.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- csi_rx.f
+incdir+logic
logic/csi_rx_pkg.sv
logic/csi_header_ecc.sv
logic/csi_packet_parser.sv
logic/raw10_unpacker.sv
logic/video_sync_out.sv
logic/csi_rx_top.sv
tb/tb_csi_rx.sv

//--- logic/csi_header_ecc.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_consts.svh"

module csi_header_ecc (
    input  logic [3*`CSI_BYTE_W-1:0] hdr_i,
    input  csi_rx_pkg::csi_ecc_t     ecc_i,
    output logic                     ecc_ok_o
);
    import csi_rx_pkg::*;

    // header bits covered by each parity bit
    // bit 0 of the mask is d0, the lsb of the data id byte
    localparam logic [3*`CSI_BYTE_W-1:0] parity_mask [6] = '{
        24'hF12CB7,
        24'hF2555B,
        24'h749A6D,
        24'hB8E38E,
        24'hDF03F0,
        24'hEFFC00
    };

    // locally computed ecc byte
    csi_ecc_t ecc_calc;

    always_comb
    begin
        // p7 and p6 are always zero for a 24-bit header
        ecc_calc = '0;
        for (int i = 0; i < 6; i++)
        begin
            // even parity over the masked bits
            ecc_calc[i] = ^(hdr_i & parity_mask[i]);
        end
    end

    // any mismatch rejects the header, no single-bit repair
    assign ecc_ok_o = (ecc_calc == ecc_i);

endmodule

`default_nettype wire

//--- logic/csi_packet_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_consts.svh"

module csi_packet_parser (
    input  logic                  clk_byte_hs,
    input  logic                  reset_n_i,
    input  csi_rx_pkg::csi_byte_t lane0_byte_i,
    input  csi_rx_pkg::csi_byte_t lane1_byte_i,
    input  csi_rx_pkg::csi_byte_t lane2_byte_i,
    input  csi_rx_pkg::csi_byte_t lane3_byte_i,
    input  logic                  word_stb_i,
    input  logic                  pkt_start_i,
    output logic                  pay_stb_o,
    output csi_rx_pkg::csi_word_t pay_word_o,
    output csi_rx_pkg::byte_cnt_t pay_cnt_o,
    output logic                  pay_last_o,
    output logic                  fs_stb_o,
    output logic                  fe_stb_o,
    output logic                  ecc_err_o
);
    import csi_rx_pkg::*;

    // lane bytes as an array, index = lane
    csi_byte_t   lane_byte [`CSI_NUM_LANES];
    csi_word_t   word;

    // header fields of the current word
    csi_dt_t     hdr_dt;
    csi_vc_t     hdr_vc;
    csi_wc_t     hdr_wc;
    csi_ecc_t    hdr_ecc;
    logic        hdr_ok;
    logic        hdr_stb;

    // bytes still owed by the open packet, payload plus crc
    logic [16:0] rem_cnt;
    logic [16:0] pay_left;
    logic [16:0] take_cnt;
    logic        in_pkt;
    // open packet carries raw10 pixels
    logic        raw10_q;

    // per-word payload view
    byte_cnt_t   word_pay_cnt;
    logic        word_pay_last;

    assign lane_byte[0] = lane0_byte_i;
    assign lane_byte[1] = lane1_byte_i;
    assign lane_byte[2] = lane2_byte_i;
    assign lane_byte[3] = lane3_byte_i;

    // lane 0 lands in the low byte
    assign word = {lane_byte[3], lane_byte[2], lane_byte[1], lane_byte[0]};

    // data id byte is vc in 7:6, dt in 5:0
    assign hdr_dt  = lane_byte[`CSI_HDR_DI_BYTE][5:0];
    assign hdr_vc  = lane_byte[`CSI_HDR_DI_BYTE][7:6];
    // word count, low byte first
    assign hdr_wc  = {lane_byte[`CSI_HDR_WC_HI_BYTE], lane_byte[`CSI_HDR_WC_LO_BYTE]};
    assign hdr_ecc = lane_byte[`CSI_HDR_ECC_BYTE];

    assign hdr_stb = word_stb_i & pkt_start_i;
    assign in_pkt  = (rem_cnt != '0);

    csi_header_ecc u_hdr_ecc (
        .hdr_i    ({hdr_wc, hdr_vc, hdr_dt}),
        .ecc_i    (hdr_ecc),
        .ecc_ok_o (hdr_ok)
    );

    always_comb
    begin
        // strip the crc tail to get the payload still to come
        if (rem_cnt > 17'(`CSI_CRC_BYTES))
        begin
            pay_left = rem_cnt - 17'(`CSI_CRC_BYTES);
        end
        else
        begin
            pay_left = '0;
        end

        // full word unless the payload ends inside it
        if (pay_left >= 17'(`CSI_NUM_LANES))
        begin
            word_pay_cnt = 3'(`CSI_NUM_LANES);
        end
        else
        begin
            word_pay_cnt = pay_left[2:0];
        end
        word_pay_last = (pay_left != '0) && (pay_left <= 17'(`CSI_NUM_LANES));

        // bytes this word removes from the packet
        if (rem_cnt >= 17'(`CSI_NUM_LANES))
        begin
            take_cnt = 17'(`CSI_NUM_LANES);
        end
        else
        begin
            take_cnt = rem_cnt;
        end
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            rem_cnt   <= '0;
            raw10_q   <= 1'b0;
            pay_stb_o <= 1'b0;
            fs_stb_o  <= 1'b0;
            fe_stb_o  <= 1'b0;
            ecc_err_o <= 1'b0;
        end
        else
        begin
            // single-cycle strobes
            pay_stb_o <= 1'b0;
            fs_stb_o  <= 1'b0;
            fe_stb_o  <= 1'b0;
            ecc_err_o <= 1'b0;

            if (hdr_stb)
            begin
                // a new header always closes whatever was open
                rem_cnt <= '0;
                if (!hdr_ok)
                begin
                    ecc_err_o <= 1'b1;
                end
                else if (hdr_dt >= `CSI_DT_LONG_MIN)
                begin
                    // long packet, count payload then crc
                    rem_cnt <= {1'b0, hdr_wc} + 17'(`CSI_CRC_BYTES);
                    raw10_q <= (hdr_dt == `CSI_DT_RAW10);
                end
                else
                begin
                    // short packet, only frame events matter here
                    fs_stb_o <= (hdr_dt == `CSI_DT_FRAME_START);
                    fe_stb_o <= (hdr_dt == `CSI_DT_FRAME_END);
                end
            end
            else if (word_stb_i && in_pkt)
            begin
                rem_cnt   <= rem_cnt - take_cnt;
                // other data types are counted through silently
                pay_stb_o <= raw10_q && (pay_left != '0);
            end
        end
    end

    // payload side, qualified by pay_stb_o
    always_ff @(posedge clk_byte_hs)
    begin
        if (word_stb_i)
        begin
            pay_word_o <= word;
            pay_cnt_o  <= word_pay_cnt;
            pay_last_o <= word_pay_last;
        end
    end

endmodule

`default_nettype wire

//--- logic/csi_rx_consts.svh
`ifndef CSI_RX_CONSTS_SVH
`define CSI_RX_CONSTS_SVH

// lane group geometry
`define CSI_NUM_LANES       4
`define CSI_BYTE_W          8

// raw10 packing, five bytes carry four pixels
`define CSI_PIX_W           10
`define CSI_PIX_PER_GROUP   4
`define CSI_BYTES_PER_GROUP 5

// data type codes
`define CSI_DT_FRAME_START  6'h00
`define CSI_DT_FRAME_END    6'h01
// long packets start here
`define CSI_DT_LONG_MIN     6'h10
`define CSI_DT_RAW10        6'h2B

// byte slots in the packet header word
`define CSI_HDR_DI_BYTE     0
`define CSI_HDR_WC_LO_BYTE  1
`define CSI_HDR_WC_HI_BYTE  2
`define CSI_HDR_ECC_BYTE    3

// crc trailer after a long packet payload
`define CSI_CRC_BYTES       2

`endif

//--- logic/csi_rx_pkg.sv
`default_nettype none

`include "csi_rx_consts.svh"

package csi_rx_pkg;

    // one byte from one lane
    typedef logic [`CSI_BYTE_W-1:0] csi_byte_t;

    // all lanes together, lane 0 in the low byte and first in time
    typedef logic [`CSI_NUM_LANES*`CSI_BYTE_W-1:0] csi_word_t;

    // header fields
    typedef logic [5:0]  csi_dt_t;
    typedef logic [1:0]  csi_vc_t;
    typedef logic [15:0] csi_wc_t;
    typedef logic [7:0]  csi_ecc_t;

    // valid bytes in a payload word, 1 to 4
    typedef logic [2:0] byte_cnt_t;

    // one raw10 pixel
    typedef logic [`CSI_PIX_W-1:0] pix_t;

    // four pixels, pixel 0 in the low bits
    typedef logic [`CSI_PIX_PER_GROUP*`CSI_PIX_W-1:0] pix_group_t;

endpackage

`default_nettype wire

//--- logic/csi_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_top (
    input  logic                   clk_byte_hs,
    input  logic                   reset_n_i,
    input  csi_rx_pkg::csi_byte_t  lane0_byte_i,
    input  csi_rx_pkg::csi_byte_t  lane1_byte_i,
    input  csi_rx_pkg::csi_byte_t  lane2_byte_i,
    input  csi_rx_pkg::csi_byte_t  lane3_byte_i,
    input  logic                   word_stb_i,
    input  logic                   pkt_start_i,
    output logic                   fv_o,
    output logic                   lv_o,
    output logic                   pix_valid_o,
    output csi_rx_pkg::pix_group_t pix_group_o,
    output logic                   ecc_err_o
);
    import csi_rx_pkg::*;

    // parser to unpacker
    logic       pay_stb;
    csi_word_t  pay_word;
    byte_cnt_t  pay_cnt;
    logic       pay_last;
    logic       pkt_fs_stb;
    logic       pkt_fe_stb;

    // unpacker to output stage
    logic       grp_stb;
    pix_group_t grp_pix;
    logic       grp_last;
    logic       grp_fs_stb;
    logic       grp_fe_stb;

    csi_packet_parser u_parser (
        .clk_byte_hs  (clk_byte_hs),
        .reset_n_i    (reset_n_i),
        .lane0_byte_i (lane0_byte_i),
        .lane1_byte_i (lane1_byte_i),
        .lane2_byte_i (lane2_byte_i),
        .lane3_byte_i (lane3_byte_i),
        .word_stb_i   (word_stb_i),
        .pkt_start_i  (pkt_start_i),
        .pay_stb_o    (pay_stb),
        .pay_word_o   (pay_word),
        .pay_cnt_o    (pay_cnt),
        .pay_last_o   (pay_last),
        .fs_stb_o     (pkt_fs_stb),
        .fe_stb_o     (pkt_fe_stb),
        .ecc_err_o    (ecc_err_o)
    );

    raw10_unpacker u_unpacker (
        .clk_byte_hs (clk_byte_hs),
        .reset_n_i   (reset_n_i),
        .pay_stb_i   (pay_stb),
        .pay_word_i  (pay_word),
        .pay_cnt_i   (pay_cnt),
        .pay_last_i  (pay_last),
        .fs_stb_i    (pkt_fs_stb),
        .fe_stb_i    (pkt_fe_stb),
        .grp_stb_o   (grp_stb),
        .grp_pix_o   (grp_pix),
        .grp_last_o  (grp_last),
        .fs_stb_o    (grp_fs_stb),
        .fe_stb_o    (grp_fe_stb)
    );

    video_sync_out u_sync_out (
        .clk_byte_hs (clk_byte_hs),
        .reset_n_i   (reset_n_i),
        .grp_stb_i   (grp_stb),
        .grp_pix_i   (grp_pix),
        .grp_last_i  (grp_last),
        .fs_stb_i    (grp_fs_stb),
        .fe_stb_i    (grp_fe_stb),
        .fv_o        (fv_o),
        .lv_o        (lv_o),
        .pix_valid_o (pix_valid_o),
        .pix_group_o (pix_group_o)
    );

endmodule

`default_nettype wire

//--- logic/raw10_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_consts.svh"

module raw10_unpacker (
    input  logic                   clk_byte_hs,
    input  logic                   reset_n_i,
    input  logic                   pay_stb_i,
    input  csi_rx_pkg::csi_word_t  pay_word_i,
    input  csi_rx_pkg::byte_cnt_t  pay_cnt_i,
    input  logic                   pay_last_i,
    input  logic                   fs_stb_i,
    input  logic                   fe_stb_i,
    output logic                   grp_stb_o,
    output csi_rx_pkg::pix_group_t grp_pix_o,
    output logic                   grp_last_o,
    output logic                   fs_stb_o,
    output logic                   fe_stb_o
);
    import csi_rx_pkg::*;

    // at most 4 held plus one 4-byte word
    localparam int acc_depth = 2 * `CSI_NUM_LANES;

    // byte accumulator, byte 0 is the oldest
    csi_byte_t  acc_q    [acc_depth];
    csi_byte_t  acc_fill [acc_depth];
    csi_byte_t  acc_next [acc_depth];
    logic [3:0] fill_q;
    logic [3:0] fill_sum;
    logic [3:0] fill_next;
    logic       grp_done;
    pix_group_t grp_pix;

    always_comb
    begin
        // append the new word behind the held bytes
        acc_fill = acc_q;
        for (int i = 0; i < `CSI_NUM_LANES; i++)
        begin
            if (pay_stb_i && (i < int'(pay_cnt_i)))
            begin
                acc_fill[int'(fill_q) + i] = pay_word_i[i*`CSI_BYTE_W +: `CSI_BYTE_W];
            end
        end

        fill_sum = fill_q + {1'b0, pay_cnt_i};
        grp_done = pay_stb_i && (fill_sum >= 4'(`CSI_BYTES_PER_GROUP));

        // drop one group worth of bytes from the front
        for (int j = 0; j < acc_depth; j++)
        begin
            if (j < acc_depth - `CSI_BYTES_PER_GROUP)
            begin
                acc_next[j] = acc_fill[j + `CSI_BYTES_PER_GROUP];
            end
            else
            begin
                acc_next[j] = acc_fill[j];
            end
        end

        // msbs from bytes 0..3, lsb pairs packed in byte 4
        for (int k = 0; k < `CSI_PIX_PER_GROUP; k++)
        begin
            grp_pix[k*`CSI_PIX_W +: `CSI_PIX_W] =
                {acc_fill[k], acc_fill[`CSI_BYTES_PER_GROUP-1][2*k +: 2]};
        end

        // leftovers at packet end are thrown away
        if (!pay_stb_i)
            fill_next = fill_q;
        else if (pay_last_i)
            fill_next = '0;
        else if (grp_done)
            fill_next = fill_sum - 4'(`CSI_BYTES_PER_GROUP);
        else
            fill_next = fill_sum;
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            fill_q    <= '0;
            grp_stb_o <= 1'b0;
            fs_stb_o  <= 1'b0;
            fe_stb_o  <= 1'b0;
        end
        else
        begin
            fill_q    <= fill_next;
            grp_stb_o <= grp_done;
            // one cycle delay keeps frame events behind the groups
            fs_stb_o  <= fs_stb_i;
            fe_stb_o  <= fe_stb_i;
        end
    end

    always_ff @(posedge clk_byte_hs)
    begin
        if (grp_done)
            acc_q <= acc_next;
        else
            acc_q <= acc_fill;
        if (grp_done)
        begin
            grp_pix_o  <= grp_pix;
            // the group built in the last word cycle closes the line
            grp_last_o <= pay_last_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/video_sync_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_sync_out (
    input  logic                   clk_byte_hs,
    input  logic                   reset_n_i,
    input  logic                   grp_stb_i,
    input  csi_rx_pkg::pix_group_t grp_pix_i,
    input  logic                   grp_last_i,
    input  logic                   fs_stb_i,
    input  logic                   fe_stb_i,
    output logic                   fv_o,
    output logic                   lv_o,
    output logic                   pix_valid_o,
    output csi_rx_pkg::pix_group_t pix_group_o
);

    // last group of the line went out last cycle
    logic line_end_q;

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            fv_o        <= 1'b0;
            lv_o        <= 1'b0;
            pix_valid_o <= 1'b0;
            line_end_q  <= 1'b0;
        end
        else
        begin
            pix_valid_o <= grp_stb_i;
            line_end_q  <= grp_stb_i & grp_last_i;

            // frame valid spans frame start to frame end
            if (fs_stb_i)
                fv_o <= 1'b1;
            else if (fe_stb_i)
                fv_o <= 1'b0;

            // line valid opens with the first group
            // and closes one cycle after the last one
            if (grp_stb_i)
                lv_o <= 1'b1;
            else if (line_end_q)
                lv_o <= 1'b0;
        end
    end

    // pixel data, qualified by pix_valid_o
    always_ff @(posedge clk_byte_hs)
    begin
        if (grp_stb_i)
        begin
            pix_group_o <= grp_pix_i;
        end
    end

endmodule

`default_nettype wire

//--- tb/csi_rx_stimulus.txt
# T name | I idle gaps 0/1 | H data_id word_count xor_mask (tb adds ecc) | P payload word
# G expected pixel group | C ecc_errors groups fv | E end of test
T reset_frame_start
I 0
H 00 0001 00000000
C 0 0 1
E
T raw10_wc20
I 0
G 04C0E02404
G 400C020040
G FFFFFFFFFF
G 0040100401
H 2B 0014 00000000
P 04030201
P 302010E4
P FFFF0040
P 00FFFFFF
P 55000000
P 0000BEEF
C 0 4 1
E
T raw10_wc10
I 0
G 8320981A03
G 0300801000
H 2B 000A 00000000
P 83828180
P 0201001B
P CDAB0003
C 0 2 1
E
T back_to_back
I 0
G 8320981A03
G 0300801000
G 8320981A03
G 0300801000
H 2B 000A 00000000
P 83828180
P 0201001B
P CDAB0003
H 2B 000A 00000000
P 83828180
P 0201001B
P CDAB0003
C 0 4 1
E
T bad_ecc
I 0
H 2B 000A 00000100
P 83828180
P 0201001B
P CDAB0003
C 1 0 1
E
T raw8_skip
I 0
G 8320981A03
G 0300801000
H 2A 0014 00000000
P 04030201
P 302010E4
P FFFF0040
P 00FFFFFF
P 55000000
P 0000BEEF
H 2B 000A 00000000
P 83828180
P 0201001B
P CDAB0003
C 0 2 1
E
T random_gaps
I 1
G 04C0E02404
G 400C020040
G FFFFFFFFFF
G 0040100401
G 8320981A03
G 0300801000
H 2B 0014 00000000
P 04030201
P 302010E4
P FFFF0040
P 00FFFFFF
P 55000000
P 0000BEEF
H 2B 000A 00000000
P 83828180
P 0201001B
P CDAB0003
H 01 0001 00000000
C 0 6 0
E

//--- tb/tb_csi_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_consts.svh"

module tb_csi_rx;
    import csi_rx_pkg::*;

    // cycles allowed for groups to come out
    localparam int drain_timeout = 200;
    // covers the pipeline depth after the last word
    localparam int quiet_cycles  = 6;

    logic       clk_byte_hs;
    logic       reset_n_i;
    csi_byte_t  lane0_byte_i;
    csi_byte_t  lane1_byte_i;
    csi_byte_t  lane2_byte_i;
    csi_byte_t  lane3_byte_i;
    logic       word_stb_i;
    logic       pkt_start_i;
    logic       fv_o;
    logic       lv_o;
    logic       pix_valid_o;
    pix_group_t pix_group_o;
    logic       ecc_err_o;

    // expected groups in arrival order
    pix_group_t  exp_q [$];
    pix_group_t  exp_grp;
    int          errors;
    int          grp_seen;
    int          ecc_seen;
    // rising edges of lv_o in the current test
    int          lines_seen;
    int          exp_lines;
    logic        lv_prev;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr;
    logic        gaps_on;
    logic        timed_out;

    csi_rx_top DUT (
        .clk_byte_hs  (clk_byte_hs),
        .reset_n_i    (reset_n_i),
        .lane0_byte_i (lane0_byte_i),
        .lane1_byte_i (lane1_byte_i),
        .lane2_byte_i (lane2_byte_i),
        .lane3_byte_i (lane3_byte_i),
        .word_stb_i   (word_stb_i),
        .pkt_start_i  (pkt_start_i),
        .fv_o         (fv_o),
        .lv_o         (lv_o),
        .pix_valid_o  (pix_valid_o),
        .pix_group_o  (pix_group_o),
        .ecc_err_o    (ecc_err_o)
    );

    // 100 ns byte clock
    initial clk_byte_hs = 1'b0;
    always #50 clk_byte_hs = ~clk_byte_hs;

    // csi-2 hamming parity where d0 is the lsb of the data id
    function automatic csi_ecc_t header_ecc(input logic [23:0] d);
        csi_ecc_t p;
        p = '0;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
             ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
             ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
             ^ d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
             ^ d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // galois lfsr stepped once per bit
    task automatic take_bit(output logic b);
        b = lfsr[0];
        if (lfsr[0])
            lfsr = (lfsr >> 1) ^ 32'h8020_0003;
        else
            lfsr = lfsr >> 1;
    endtask

    // one strobed word followed by 0..3 idle cycles when gaps are on
    task automatic send_word(input csi_word_t w, input logic start);
        logic b0;
        logic b1;
        int   gap;
        @(negedge clk_byte_hs);
        lane0_byte_i = w[0*`CSI_BYTE_W +: `CSI_BYTE_W];
        lane1_byte_i = w[1*`CSI_BYTE_W +: `CSI_BYTE_W];
        lane2_byte_i = w[2*`CSI_BYTE_W +: `CSI_BYTE_W];
        lane3_byte_i = w[3*`CSI_BYTE_W +: `CSI_BYTE_W];
        word_stb_i   = 1'b1;
        pkt_start_i  = start;
        gap = 0;
        if (gaps_on)
        begin
            take_bit(b0);
            take_bit(b1);
            gap = int'({b1, b0});
        end
        for (int i = 0; i < gap; i++)
        begin
            @(negedge clk_byte_hs);
            word_stb_i  = 1'b0;
            pkt_start_i = 1'b0;
        end
    endtask

    task automatic go_idle();
        @(negedge clk_byte_hs);
        word_stb_i  = 1'b0;
        pkt_start_i = 1'b0;
    endtask

    task automatic wait_groups(input int expected);
        int cycles;
        cycles = 0;
        while (grp_seen < expected && cycles < drain_timeout)
        begin
            @(negedge clk_byte_hs);
            cycles++;
        end
        if (grp_seen < expected)
        begin
            $display("Timeout: waited %0d cycles for %0d pixel groups but saw only %0d",
                     drain_timeout, expected, grp_seen);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_line_idle();
        int cycles;
        cycles = 0;
        while (lv_o && cycles < drain_timeout)
        begin
            @(negedge clk_byte_hs);
            cycles++;
        end
        if (lv_o)
        begin
            $display("Timeout: line valid stayed high for %0d cycles after the last word",
                     drain_timeout);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // drains the pipeline, compares the counts and reports one line
    task automatic finish_test(input string name, input int exp_ecc, input int exp_groups,
                               input int exp_fv, input int err_start);
        go_idle();
        wait_groups(exp_groups);
        if (!timed_out)
            wait_line_idle();
        repeat (quiet_cycles) @(negedge clk_byte_hs);
        assert (grp_seen == exp_groups)
        else
        begin
            $display("Error t=%0t: %s gave %0d pixel groups, expected %0d",
                     $time, name, grp_seen, exp_groups);
            errors++;
        end
        assert (ecc_seen == exp_ecc)
        else
        begin
            $display("Error t=%0t: %s gave %0d ecc errors, expected %0d",
                     $time, name, ecc_seen, exp_ecc);
            errors++;
        end
        assert (fv_o == exp_fv[0])
        else
        begin
            $display("Error t=%0t: %s left fv_o at %0b, expected %0d",
                     $time, name, fv_o, exp_fv);
            errors++;
        end
        assert (!lv_o)
        else
        begin
            $display("Error t=%0t: %s left lv_o high after the line", $time, name);
            errors++;
        end
        // each line must open and close lv_o on its own
        assert (lines_seen == exp_lines)
        else
        begin
            $display("Error t=%0t: %s gave %0d lines on lv_o, expected %0d",
                     $time, name, lines_seen, exp_lines);
            errors++;
        end
        exp_q.delete();
        tests_run++;
        if (errors > err_start)
            tests_failed++;
        $display("test %s: %s (groups %0d, lines %0d, ecc errors %0d)", name,
                 (errors > err_start) ? "FAIL" : "ok", grp_seen, lines_seen, ecc_seen);
    endtask

    // output monitor samples away from the rising edge
    always @(negedge clk_byte_hs)
    begin
        if (reset_n_i)
        begin
            if (ecc_err_o)
                ecc_seen++;
            if (lv_o && !lv_prev)
                lines_seen++;
            lv_prev = lv_o;
            if (pix_valid_o)
            begin
                grp_seen++;
                assert (lv_o)
                else
                begin
                    $display("Error t=%0t: pixel group with lv_o low", $time);
                    errors++;
                end
                assert (exp_q.size() != 0)
                else
                begin
                    $display("Error t=%0t: unexpected pixel group %h", $time, pix_group_o);
                    errors++;
                end
                if (exp_q.size() != 0)
                begin
                    exp_grp = exp_q.pop_front();
                    assert (pix_group_o == exp_grp)
                    else
                    begin
                        $display("Error t=%0t: pixel group %h, expected %h",
                                 $time, pix_group_o, exp_grp);
                        errors++;
                    end
                end
            end
        end
    end

    initial
    begin
        int          fd;
        int          code;
        int          ival;
        string       line;
        string       name;
        logic [7:0]  di;
        logic [15:0] wc;
        logic [31:0] flip;
        csi_word_t   word;
        pix_group_t  grp;
        int          exp_ecc;
        int          exp_groups;
        int          exp_fv;
        int          err_start;

        reset_n_i    = 1'b0;
        lane0_byte_i = '0;
        lane1_byte_i = '0;
        lane2_byte_i = '0;
        lane3_byte_i = '0;
        word_stb_i   = 1'b0;
        pkt_start_i  = 1'b0;
        errors       = 0;
        grp_seen     = 0;
        ecc_seen     = 0;
        lines_seen   = 0;
        exp_lines    = 0;
        lv_prev      = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        gaps_on      = 1'b0;
        timed_out    = 1'b0;
        lfsr         = 32'd80330;
        name         = "none";
        exp_ecc      = 0;
        exp_groups   = 0;
        exp_fv       = 0;
        err_start    = 0;

        repeat (8) @(negedge clk_byte_hs);
        reset_n_i = 1'b1;

        // all outputs quiet out of reset
        assert (!fv_o && !lv_o && !pix_valid_o && !ecc_err_o)
        else
        begin
            $display("Error t=%0t: outputs not low after reset", $time);
            errors++;
        end

        fd = $fopen("tb/csi_rx_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tb/csi_rx_stimulus.txt");
            errors++;
        end

        while (fd != 0 && !$feof(fd) && !timed_out)
        begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 1)
                continue;
            case (line.getc(0))
                "T":
                begin
                    code       = $sscanf(line, "T %s", name);
                    err_start  = errors;
                    grp_seen   = 0;
                    ecc_seen   = 0;
                    lines_seen = 0;
                    exp_lines  = 0;
                    exp_ecc    = 0;
                    exp_groups = 0;
                    exp_fv     = 0;
                end
                "I":
                begin
                    code    = $sscanf(line, "I %d", ival);
                    gaps_on = (ival != 0);
                end
                "H":
                begin
                    code = $sscanf(line, "H %h %h %h", di, wc, flip);
                    // data id in byte 0 then word count low and high with ecc on top
                    word = {header_ecc({wc, di}), wc, di} ^ flip;
                    // an intact raw10 header long enough for one group opens a line
                    if (flip == '0 && di[5:0] == `CSI_DT_RAW10
                        && wc >= 16'(`CSI_BYTES_PER_GROUP))
                        exp_lines++;
                    send_word(word, 1'b1);
                end
                "P":
                begin
                    code = $sscanf(line, "P %h", word);
                    send_word(word, 1'b0);
                end
                "G":
                begin
                    code = $sscanf(line, "G %h", grp);
                    exp_q.push_back(grp);
                end
                "C":
                begin
                    code = $sscanf(line, "C %d %d %d", exp_ecc, exp_groups, exp_fv);
                end
                "E":
                begin
                    finish_test(name, exp_ecc, exp_groups, exp_fv, err_start);
                end
                default:
                begin
                    // comments and blank lines
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
